// File: logic/fifo_config.svh
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// Sizing for the SCSI DMA longword FIFO
// The 16-bit bus side delivers halfwords and the memory side takes longwords

// Number of longword entries held in the store
// The thermometer occupancy code is this many bits wide
`define FIFO_DEPTH 8

// Width of one bus halfword
// A stored longword is twice this width
`define FIFO_HALF_W 16

// Store address width
// Must stay equal to log2 of FIFO_DEPTH so the pointers wrap on their own
`define FIFO_PTR_W 3

`endif

// File: logic/fifo_pkg.sv
`include "fifo_config.svh"

package fifo_pkg;

  // One halfword as it arrives from the 16-bit bus
  typedef logic [`FIFO_HALF_W-1:0] half_t;

  // One packed longword, first halfword in the low half
  typedef logic [2*`FIFO_HALF_W-1:0] word_t;

  // Thermometer occupancy
  // Bit k is set when more than k entries are held
  typedef logic [`FIFO_DEPTH-1:0] level_t;

  // Address into the longword store
  typedef logic [`FIFO_PTR_W-1:0] ptr_t;

  // Packer states
  // LOW_HALF waits for the low half of a longword
  // HIGH_HALF holds the low half and waits for the high half
  typedef enum logic {
    LOW_HALF,
    HIGH_HALF
  } pack_state_t;

endpackage

// File: logic/fifo_fill_ctr.sv
`timescale 1ns/100ps
`include "fifo_config.svh"

module fifo_fill_ctr
  import fifo_pkg::*;
(
  input  logic DECFIFO,
  input  logic FIFOEMPTY_RST,
  input  logic inc,
  input  logic dec,
  output logic fifo_full,
  output logic fifo_empty
);

  // Current and next thermometer occupancy
  level_t level_q;
  level_t level_d;

  // An increment fills from the bottom, a decrement drains from the top
  // When both strobes are high in one cycle the count holds
  always_comb
  begin
    level_d = level_q;
    if (inc && !dec)
    begin
      // Shift a one in at bit 0
      level_d = {level_q[`FIFO_DEPTH-2:0], 1'b1};
    end
    else if (dec && !inc)
    begin
      // Drop the highest set bit
      level_d = {1'b0, level_q[`FIFO_DEPTH-1:1]};
    end
  end

  // Occupancy register, empty after reset
  always_ff @(posedge DECFIFO or negedge FIFOEMPTY_RST)
  begin
    if (!FIFOEMPTY_RST)
      level_q <= '0;
    else
      level_q <= level_d;
  end

  // Flags are taken from the next level so they line up with the level itself
  // Full means every entry holds a word, empty means not even one does
  always_ff @(posedge DECFIFO or negedge FIFOEMPTY_RST)
  begin
    if (!FIFOEMPTY_RST)
    begin
      fifo_full  <= 1'b0;
      fifo_empty <= 1'b1;
    end
    else
    begin
      fifo_full  <= level_d[`FIFO_DEPTH-1];
      fifo_empty <= ~level_d[0];
    end
  end

  // The level must always be a run of ones from bit 0 upward
  // Adding one to such a code leaves no bit shared with the original
  a_level_thermo : assert property (
    @(posedge DECFIFO) disable iff (!FIFOEMPTY_RST)
    ((level_q + 1'b1) & level_q) == '0
  );

  // The packer must stall before the counter would overflow
  a_no_inc_when_full : assert property (
    @(posedge DECFIFO) disable iff (!FIFOEMPTY_RST)
    fifo_full |-> !(inc && !dec)
  );

  // The output side must not read an empty FIFO
  a_no_dec_when_empty : assert property (
    @(posedge DECFIFO) disable iff (!FIFOEMPTY_RST)
    fifo_empty |-> !(dec && !inc)
  );

endmodule

// File: logic/fifo_pack_fsm.sv
`timescale 1ns/100ps

module fifo_pack_fsm
  import fifo_pkg::*;
(
  input  logic  DECFIFO,
  input  logic  FIFOEMPTY_RST,
  input  logic  in_valid,
  input  half_t in_half,
  input  logic  in_last,
  output logic  in_ready,
  input  logic  fifo_full,
  output logic  wr_en,
  output word_t wr_word
)
;

  pack_state_t state_q;

  // Low half waiting for its partner
  half_t low_q;

  // A halfword moves on this edge
  logic accept;

  // In LOW_HALF a lone last halfword needs a free entry, and in HIGH_HALF
  // the completing halfword does too, so both states stall on full
  // The full flag is registered, so out_ready never reaches in_ready
  assign in_ready = ~fifo_full;
  assign accept   = in_valid & in_ready;

  // Write strobe and data to the store
  always_comb
  begin
    wr_en   = 1'b0;
    wr_word = {half_t'(0), in_half};
    if (state_q == HIGH_HALF)
    begin
      // Second halfword goes on top of the held first one
      wr_word = {in_half, low_q};
      wr_en   = accept;
    end
    else
    begin
      // A last halfword in the low slot is flushed with a zero upper half
      wr_en = accept & in_last;
    end
  end

  // State register
  always_ff @(posedge DECFIFO or negedge FIFOEMPTY_RST)
  begin
    if (!FIFOEMPTY_RST)
      state_q <= LOW_HALF;
    else if (accept)
    begin
      if (state_q == HIGH_HALF)
        state_q <= LOW_HALF;
      else if (!in_last)
        state_q <= HIGH_HALF;
    end
  end

  // Capture the low half of a longword as it is accepted
  always_ff @(posedge DECFIFO)
  begin
    if (accept && (state_q == LOW_HALF))
      low_q <= in_half;
  end

  // A stalled halfword must still be offered, unchanged, on the next edge
  // Otherwise the packer would pair the held low half with the wrong data
  a_src_hold : assert property (
    @(posedge DECFIFO) disable iff (!FIFOEMPTY_RST)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_half) && $stable(in_last))
  );

endmodule

// File: logic/fifo_word_store.sv
`timescale 1ns/100ps
`include "fifo_config.svh"

module fifo_word_store
  import fifo_pkg::*;
(
  input  logic  DECFIFO,
  input  logic  FIFOEMPTY_RST,
  input  logic  wr_en,
  input  word_t wr_word,
  input  logic  rd_en,
  output word_t rd_word
);

  // Longword storage, contents are undefined until written
  word_t mem [`FIFO_DEPTH];

  // Pointers wrap through the power-of-two depth without any compare
  ptr_t wr_ptr;
  ptr_t rd_ptr;

  // Entries written minus entries read, one bit wider than a pointer
  logic [`FIFO_PTR_W:0] occ_q;

  always_ff @(posedge DECFIFO)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_word;
  end

  always_ff @(posedge DECFIFO or negedge FIFOEMPTY_RST)
  begin
    if (!FIFOEMPTY_RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      // Count only moves when exactly one side is active
      if (wr_en && !rd_en)
        occ_q <= occ_q + 1'b1;
      else if (rd_en && !wr_en)
        occ_q <= occ_q - 1'b1;
    end
  end

  // Head of the queue is always on the output
  assign rd_word = mem[rd_ptr];

  // The count must never pass the depth or wrap below zero
  // Equal pointers can then only mean either no words or all of them
  a_ptr_equal : assert property (
    @(posedge DECFIFO) disable iff (!FIFOEMPTY_RST)
    occ_q <= `FIFO_DEPTH
  );

endmodule

// File: logic/fifo_top.sv
`timescale 1ns/100ps

module fifo_top
  import fifo_pkg::*;
(
  input  logic  DECFIFO,
  input  logic  FIFOEMPTY_RST,
  input  logic  in_valid,
  input  half_t in_half,
  input  logic  in_last,
  output logic  in_ready,
  output logic  out_valid,
  input  logic  out_ready,
  output word_t out_word,
  output logic  fifo_full,
  output logic  fifo_empty
);

  // Packer to store and counter
  logic  wr_en;
  word_t wr_word;

  // Longword leaves on this edge
  logic  rd_en;

  // Any held word is offered to the memory side
  assign out_valid = ~fifo_empty;
  assign rd_en     = out_valid & out_ready;

  // Halfword packer, stalls on the registered full flag
  fifo_pack_fsm pack_i (
    .DECFIFO       (DECFIFO),
    .FIFOEMPTY_RST (FIFOEMPTY_RST),
    .in_valid      (in_valid),
    .in_half       (in_half),
    .in_last       (in_last),
    .in_ready      (in_ready),
    .fifo_full     (fifo_full),
    .wr_en         (wr_en),
    .wr_word       (wr_word)
  );

  // Occupancy counter, writes count up and reads count down
  fifo_fill_ctr ctr_i (
    .DECFIFO       (DECFIFO),
    .FIFOEMPTY_RST (FIFOEMPTY_RST),
    .inc           (wr_en),
    .dec           (rd_en),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty)
  );

  // Longword register file
  fifo_word_store store_i (
    .DECFIFO       (DECFIFO),
    .FIFOEMPTY_RST (FIFOEMPTY_RST),
    .wr_en         (wr_en),
    .wr_word       (wr_word),
    .rd_en         (rd_en),
    .rd_word       (out_word)
  );

endmodule

// File: test/clk_gen.sv
`timescale 1ns/100ps

module clk_gen
#(
  parameter int half_period  = 20,
  parameter int reset_cycles = 5
)
(
  output logic DECFIFO,
  output logic FIFOEMPTY_RST
);

  // Free-running clock with a 40 ns period
  initial
  begin
    DECFIFO = 1'b0;
    forever #(half_period) DECFIFO = ~DECFIFO;
  end

  // Reset is held for a fixed number of edges and then released on an edge
  initial
  begin
    FIFOEMPTY_RST = 1'b0;
    repeat (reset_cycles) @(posedge DECFIFO);
    FIFOEMPTY_RST <= 1'b1;
  end

endmodule

// File: test/tb_fifo.sv
`timescale 1ns/100ps
`include "fifo_config.svh"

module tb_fifo
  import fifo_pkg::*;
();

  // Halfwords sent over the whole run, split over the directed and random parts
  localparam int total_halves = 400;
  localparam int random_halves = total_halves - 130;

  // 400 halfwords need well under fifty cycles each, even with random stalls
  localparam int timeout_cycles = 20000;

  logic  DECFIFO;
  logic  FIFOEMPTY_RST;
  logic  in_valid;
  half_t in_half;
  logic  in_last;
  logic  in_ready;
  logic  out_valid;
  logic  out_ready;
  word_t out_word;
  logic  fifo_full;
  logic  fifo_empty;

  // Sink behaviour: 0 always ready, 1 held off, 2 random
  int sink_mode = 1;

  // Reference model state, owned by the compare process
  word_t exp_q[$];
  int    model_count = 0;
  logic  model_high = 1'b0;
  half_t model_low;
  logic  stalled = 1'b0;
  word_t stalled_word;

  int      cycle_count = 0;
  int      seed_val;
  half_t   rand_half;

  clk_gen clk_i (
    .DECFIFO       (DECFIFO),
    .FIFOEMPTY_RST (FIFOEMPTY_RST)
  );

  fifo_top dut_i (
    .DECFIFO       (DECFIFO),
    .FIFOEMPTY_RST (FIFOEMPTY_RST),
    .in_valid      (in_valid),
    .in_half       (in_half),
    .in_last       (in_last),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_word      (out_word),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty)
  );

  // Expected longword: first halfword low, a flushed last halfword gets a zero top
  function automatic word_t pack_ref(input half_t lo, input half_t hi, input logic last);
    if (last)
      return {half_t'(0), lo};
    return {hi, lo};
  endfunction

  task automatic stop_run(input string why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run("Output word mismatch");
    end
  endtask

  task automatic compare_flags(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run("Status flag mismatch");
    end
  endtask

  // Offer one halfword and hold it until the DUT takes it
  task automatic send_half(input half_t h, input logic last);
    in_valid <= 1'b1;
    in_half  <= h;
    in_last  <= last;
    @(posedge DECFIFO);
    while (!in_ready)
      @(posedge DECFIFO);
  endtask

  // Wait on the falling edge so the model is read after the compare process ran
  task automatic wait_drained();
    do
      @(negedge DECFIFO);
    while (exp_q.size() != 0);
    @(posedge DECFIFO);
  endtask

  always @(posedge DECFIFO)
  begin
    case (sink_mode)
      0:       out_ready <= 1'b1;
      1:       out_ready <= 1'b0;
      default: out_ready <= 1'($urandom % 2);
    endcase
  end

  always @(posedge DECFIFO)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
    begin
      $display("TB FAILED");
      $fatal(1, "The test timed out after %0d cycles without draining", cycle_count);
    end
  end

  // Compare process, flags are checked against the count left by the previous edge
  always @(posedge DECFIFO)
  begin
    if (FIFOEMPTY_RST)
    begin
      compare_flags(fifo_full, model_count == `FIFO_DEPTH, "fifo_full");
      compare_flags(fifo_empty, model_count == 0, "fifo_empty");
      compare_flags(out_valid, model_count != 0, "out_valid");
      compare_flags(in_ready, model_count != `FIFO_DEPTH, "in_ready");
      // A word offered but not taken must not change
      if (stalled)
        compare_word(out_word, stalled_word, "held out_word");
      if (out_valid && out_ready)
      begin
        if (exp_q.size() == 0)
          stop_run("The DUT presented a word that the model never expected");
        else
        begin
          compare_word(out_word, exp_q.pop_front(), "out_word");
          model_count--;
        end
      end
      stalled      = out_valid && !out_ready;
      stalled_word = out_word;
      if (in_valid && in_ready)
      begin
        if (model_high)
        begin
          exp_q.push_back(pack_ref(model_low, in_half, 1'b0));
          model_count++;
          model_high = 1'b0;
        end
        else if (in_last)
        begin
          exp_q.push_back(pack_ref(in_half, in_half, 1'b1));
          model_count++;
        end
        else
        begin
          model_low  = in_half;
          model_high = 1'b1;
        end
      end
    end
  end

  initial
  begin
    seed_val = $urandom(57006);
    in_valid  = 1'b0;
    in_half   = '0;
    in_last   = 1'b0;
    out_ready = 1'b0;

    // First edge with reset released, the FIFO must look empty and open
    @(posedge DECFIFO);
    while (!FIFOEMPTY_RST)
      @(posedge DECFIFO);
    compare_flags(fifo_empty, 1'b1, "fifo_empty after reset");
    compare_flags(fifo_full, 1'b0, "fifo_full after reset");
    compare_flags(out_valid, 1'b0, "out_valid after reset");
    compare_flags(in_ready, 1'b1, "in_ready after reset");

    // Back-to-back pairs into an always-ready sink
    sink_mode <= 0;
    for (int i = 0; i < 80; i++)
    begin
      rand_half = half_t'($urandom);
      send_half(rand_half, 1'b0);
    end

    // Lone last halves in the low slot, each followed by a full pair
    for (int i = 0; i < 10; i++)
    begin
      send_half(half_t'($urandom), 1'b1);
      send_half(half_t'($urandom), 1'b0);
      send_half(half_t'($urandom), 1'b0);
    end
    in_valid <= 1'b0;
    wait_drained();

    // Fill all eight entries with the sink held off
    sink_mode <= 1;
    repeat (2) @(posedge DECFIFO);
    for (int i = 0; i < 16; i++)
      send_half(half_t'($urandom), 1'b0);
    in_valid <= 1'b0;
    while (!fifo_full)
      @(posedge DECFIFO);
    compare_flags(in_ready, 1'b0, "in_ready while full");

    // The next halfword waits until the sink starts reading again
    fork
      send_half(half_t'($urandom), 1'b0);
      begin
        repeat (12) @(posedge DECFIFO);
        sink_mode <= 0;
      end
    join
    for (int i = 0; i < 3; i++)
      send_half(half_t'($urandom), 1'b0);

    // Random gaps, random last marks and a random sink
    sink_mode <= 2;
    for (int i = 0; i < random_halves; i++)
    begin
      if ($urandom % 4 == 0)
      begin
        in_valid <= 1'b0;
        @(posedge DECFIFO);
      end
      // The final halfword is marked last so no low half is left behind
      send_half(half_t'($urandom), (i == random_halves - 1) || ($urandom % 8 == 0));
    end
    in_valid <= 1'b0;
    sink_mode <= 0;
    wait_drained();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_fill_ctr.sv
logic/fifo_pack_fsm.sv
logic/fifo_word_store.sv
logic/fifo_top.sv
test/clk_gen.sv
test/tb_fifo.sv

// File: Bender.yml
package:
  name: scsi_dma_fifo

export_include_dirs:
  - logic

sources:
  - logic/fifo_pkg.sv
  - logic/fifo_fill_ctr.sv
  - logic/fifo_pack_fsm.sv
  - logic/fifo_word_store.sv
  - logic/fifo_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/tb_fifo.sv
